// ==== project.f ====
verilog/conv_pkg.sv
verilog/weight_stream_rx.sv
verilog/tap_fifo.sv
verilog/kernel_weight_buffer.sv
verilog/window_mac.sv
verilog/conv3x3_core.sv
testbench/conv3x3_core_tb.sv

// ==== testbench/conv3x3_core_tb.sv ====
`timescale 1ns/1ns

module conv3x3_core_tb;

	import conv_pkg::*;

	localparam int kernel_bits = KERNEL_SIZE * DATA_WIDTH;
	// Whole run needs about 2500 cycles
	localparam int timeout_cycles = 20000;

	logic                  clk;
	logic                  reset;
	logic                  w_req;
	logic [DATA_WIDTH-1:0] w_data;
	logic                  w_ack;
	logic                  p_req;
	logic [DATA_WIDTH-1:0] p_data;
	win_op_t               p_op;
	logic                  p_ack;
	logic                  res_req;
	logic [ACC_WIDTH-1:0]  res_data;
	logic                  res_ack;

	// Reference model: kernels sent but not popped, and the taps now held
	logic [kernel_bits-1:0] kernel_q [$];
	logic [kernel_bits-1:0] held_taps;

	integer seed;
	int     cycle_count = 0;
	int     check_count;
	int     error_count;
	int     test_count;
	int     errors_at_start;

	conv3x3_core UUT (
		.clk(clk), .reset(reset), .w_req(w_req), .w_data(w_data), .w_ack(w_ack),
		.p_req(p_req), .p_data(p_data), .p_op(p_op), .p_ack(p_ack),
		.res_req(res_req), .res_data(res_data), .res_ack(res_ack)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout after %0d cycles, a handshake never completed", cycle_count);
			$display("*** FAILED ***");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks and reference model
	//////////////////////////////////////////////////////////////////////
	task automatic check_result(input string name, input logic signed [ACC_WIDTH-1:0] actual,
		input logic signed [ACC_WIDTH-1:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
				$time, name, actual, expected);
		end
	endtask

	function automatic logic signed [ACC_WIDTH-1:0] dot_product(
		input logic [kernel_bits-1:0] taps, input logic [kernel_bits-1:0] pixels);
		logic signed [ACC_WIDTH-1:0]  sum;
		logic signed [DATA_WIDTH-1:0] tap;
		logic signed [DATA_WIDTH-1:0] pixel;
		sum = '0;
		for (int k = 0; k < KERNEL_SIZE; k++) begin
			tap   = taps[k*DATA_WIDTH +: DATA_WIDTH];
			pixel = pixels[k*DATA_WIDTH +: DATA_WIDTH];
			sum   = sum + tap * pixel;
		end
		return sum;
	endfunction

	// Extreme values come up about three words in sixteen
	function automatic logic [DATA_WIDTH-1:0] random_word();
		logic [31:0] r;
		r = $random(seed);
		case (r[3:0])
			4'd0:    return 16'h8000;
			4'd1:    return 16'h7fff;
			4'd2:    return 16'hffff;
			default: return r[31:16];
		endcase
	endfunction

	function automatic logic [kernel_bits-1:0] random_words();
		logic [kernel_bits-1:0] words;
		for (int k = 0; k < KERNEL_SIZE; k++) begin
			words[k*DATA_WIDTH +: DATA_WIDTH] = random_word();
		end
		return words;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Host side of the three channels
	//////////////////////////////////////////////////////////////////////
	task automatic send_word(input logic [DATA_WIDTH-1:0] word);
		@(negedge clk);
		w_data = word;
		w_req  = 1'b1;
		@(negedge clk);
		while (!w_ack) @(negedge clk);
		w_req = 1'b0;
		@(negedge clk);
		while (w_ack) @(negedge clk);
	endtask

	task automatic send_pixel(input logic [DATA_WIDTH-1:0] pixel, input win_op_t op);
		@(negedge clk);
		p_data = pixel;
		p_op   = op;
		p_req  = 1'b1;
		@(negedge clk);
		while (!p_ack) @(negedge clk);
		p_req = 1'b0;
		@(negedge clk);
		while (p_ack) @(negedge clk);
	endtask

	// Tap k is the k-th word sent
	task automatic send_kernel(input logic [kernel_bits-1:0] kernel);
		kernel_q.push_back(kernel);
		for (int k = 0; k < KERNEL_SIZE; k++) begin
			send_word(kernel[k*DATA_WIDTH +: DATA_WIDTH]);
		end
	endtask

	task automatic run_window(input win_op_t op, input int ack_delay);
		logic [kernel_bits-1:0]      pixels;
		logic signed [ACC_WIDTH-1:0] expected;
		pixels = random_words();
		for (int k = 0; k < KERNEL_SIZE; k++) begin
			send_pixel(pixels[k*DATA_WIDTH +: DATA_WIDTH], op);
		end
		if (op == WIN_NEXT) begin
			if (kernel_q.size() == 0) begin
				error_count++;
				$display("Window asked for a kernel that was never sent");
			end else begin
				held_taps = kernel_q.pop_front();
			end
		end
		expected = dot_product(held_taps, pixels);
		@(negedge clk);
		while (!res_req) @(negedge clk);
		check_result("res_data", res_data, expected);
		if (ack_delay > 0) begin
			repeat (ack_delay) @(negedge clk);
			check_result("res_data (held)", res_data, expected);
		end
		res_ack = 1'b1;
		@(negedge clk);
		while (res_req) @(negedge clk);
		res_ack = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic after_reset();
		check_result("w_ack", w_ack, 0);
		check_result("p_ack", p_ack, 0);
		check_result("res_req", res_req, 0);
		run_window(WIN_REUSE, 0);
	endtask

	task automatic single_kernel_window();
		send_kernel(random_words());
		run_window(WIN_NEXT, 1);
	endtask

	task automatic reuse_window();
		run_window(WIN_REUSE, 2);
	endtask

	// Four kernels fill the FIFOs, the fifth waits for a pop
	task automatic full_buffer();
		logic seen_ack;
		seen_ack = 1'b0;
		for (int n = 0; n < KERNEL_DEPTH; n++) begin
			send_kernel(random_words());
		end
		fork
			send_kernel(random_words());
			begin
				repeat (50) begin
					@(negedge clk);
					if (w_ack) seen_ack = 1'b1;
				end
				check_result("w_ack while full", seen_ack, 0);
				run_window(WIN_NEXT, 0);
			end
		join
		for (int n = 0; n < KERNEL_DEPTH; n++) begin
			run_window(WIN_NEXT, n);
		end
	endtask

	task automatic empty_buffer_wait();
		logic seen_ack;
		seen_ack = 1'b0;
		fork
			run_window(WIN_NEXT, 1);
			begin
				repeat (50) begin
					@(negedge clk);
					if (p_ack) seen_ack = 1'b1;
				end
				check_result("p_ack while empty", seen_ack, 0);
				send_kernel(random_words());
			end
		join
	endtask

	task automatic random_rounds();
		win_op_t op;
		for (int round = 0; round < 20; round++) begin
			if (kernel_q.size() == 0 || (kernel_q.size() < KERNEL_DEPTH && ($random(seed) & 1))) begin
				send_kernel(random_words());
			end
			op = ($random(seed) & 1) ? WIN_NEXT : WIN_REUSE;
			run_window(op, $random(seed) & 7);
		end
	endtask

	task automatic report_test(input string name);
		test_count++;
		$display("%-36s %0d errors", name, error_count - errors_at_start);
		errors_at_start = error_count;
	endtask

	initial begin
		seed            = 32'h0777_4e86;
		clk             = 1'b0;
		reset           = 1'b1;
		w_req           = 1'b0;
		w_data          = '0;
		p_req           = 1'b0;
		p_data          = '0;
		p_op            = WIN_REUSE;
		res_ack         = 1'b0;
		held_taps       = '0;
		check_count     = 0;
		error_count     = 0;
		test_count      = 0;
		errors_at_start = 0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		after_reset();
		report_test("Reset state, window before a kernel");
		single_kernel_window();
		report_test("One kernel, WIN_NEXT window");
		reuse_window();
		report_test("WIN_REUSE keeps the kernel");
		full_buffer();
		report_test("Full FIFOs hold off weights");
		empty_buffer_wait();
		report_test("Empty FIFOs hold off pixels");
		random_rounds();
		report_test("Random rounds");

		$display("Tests: %0d  checks: %0d  errors: %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== verilog/conv3x3_core.sv ====
`timescale 1ns/1ns

module conv3x3_core (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           w_req,
	input  logic [conv_pkg::DATA_WIDTH-1:0] w_data,
	output logic                           w_ack,
	input  logic                           p_req,
	input  logic [conv_pkg::DATA_WIDTH-1:0] p_data,
	input  conv_pkg::win_op_t              p_op,
	output logic                           p_ack,
	output logic                           res_req,
	output logic [conv_pkg::ACC_WIDTH-1:0]  res_data,
	input  logic                           res_ack
);

	import conv_pkg::*;

	logic                  buffer_ready;
	logic                  word_valid;
	logic [DATA_WIDTH-1:0] word_data;
	logic                  load_kernel;
	logic                  kernel_avail;
	logic                  kernel_valid;
	logic [DATA_WIDTH-1:0] tap_00, tap_01, tap_02, tap_03, tap_04;
	logic [DATA_WIDTH-1:0] tap_05, tap_06, tap_07, tap_08;

	//////////////////////////////////////////////////////////////////////
	// Producer, buffer, consumer
	//////////////////////////////////////////////////////////////////////
	weight_stream_rx u_rx (
		.clk(clk), .reset(reset), .w_req(w_req), .w_data(w_data), .w_ack(w_ack),
		.buffer_ready(buffer_ready), .word_valid(word_valid), .word_data(word_data)
	);

	kernel_weight_buffer u_buffer (
		.clk(clk), .reset(reset), .word_valid(word_valid), .word_data(word_data),
		.buffer_ready(buffer_ready), .load_kernel(load_kernel),
		.kernel_avail(kernel_avail), .kernel_valid(kernel_valid),
		.tap_00(tap_00), .tap_01(tap_01), .tap_02(tap_02), .tap_03(tap_03),
		.tap_04(tap_04), .tap_05(tap_05), .tap_06(tap_06), .tap_07(tap_07),
		.tap_08(tap_08)
	);

	window_mac u_mac (
		.clk(clk), .reset(reset), .p_req(p_req), .p_data(p_data), .p_op(p_op),
		.p_ack(p_ack), .kernel_avail(kernel_avail), .kernel_valid(kernel_valid),
		.load_kernel(load_kernel),
		.tap_00(tap_00), .tap_01(tap_01), .tap_02(tap_02), .tap_03(tap_03),
		.tap_04(tap_04), .tap_05(tap_05), .tap_06(tap_06), .tap_07(tap_07),
		.tap_08(tap_08),
		.res_req(res_req), .res_data(res_data), .res_ack(res_ack)
	);

endmodule

// ==== verilog/window_mac.sv ====
`timescale 1ns/1ns

module window_mac (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           p_req,
	input  logic [conv_pkg::DATA_WIDTH-1:0] p_data,
	input  conv_pkg::win_op_t              p_op,
	output logic                           p_ack,
	input  logic                           kernel_avail,
	input  logic                           kernel_valid,
	output logic                           load_kernel,
	input  logic [conv_pkg::DATA_WIDTH-1:0] tap_00,
	input  logic [conv_pkg::DATA_WIDTH-1:0] tap_01,
	input  logic [conv_pkg::DATA_WIDTH-1:0] tap_02,
	input  logic [conv_pkg::DATA_WIDTH-1:0] tap_03,
	input  logic [conv_pkg::DATA_WIDTH-1:0] tap_04,
	input  logic [conv_pkg::DATA_WIDTH-1:0] tap_05,
	input  logic [conv_pkg::DATA_WIDTH-1:0] tap_06,
	input  logic [conv_pkg::DATA_WIDTH-1:0] tap_07,
	input  logic [conv_pkg::DATA_WIDTH-1:0] tap_08,
	output logic                           res_req,
	output logic [conv_pkg::ACC_WIDTH-1:0]  res_data,
	input  logic                           res_ack
);

	import conv_pkg::*;

	mac_state_t                    state;
	logic [TAP_CNT_WIDTH-1:0]      pix_cnt;
	logic [DATA_WIDTH-1:0]         tap_raw;
	logic signed [DATA_WIDTH-1:0]  tap_sel;
	logic signed [2*DATA_WIDTH-1:0] product;
	logic signed [ACC_WIDTH-1:0]   acc_q;
	logic                          take;

	//////////////////////////////////////////////////////////////////////
	// Tap select and product
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (pix_cnt)
			4'd0:    tap_raw = tap_00;
			4'd1:    tap_raw = tap_01;
			4'd2:    tap_raw = tap_02;
			4'd3:    tap_raw = tap_03;
			4'd4:    tap_raw = tap_04;
			4'd5:    tap_raw = tap_05;
			4'd6:    tap_raw = tap_06;
			4'd7:    tap_raw = tap_07;
			default: tap_raw = tap_08;
		endcase
	end

	// No kernel popped yet, taps read as zero
	assign tap_sel = kernel_valid ? tap_raw : '0;
	assign product = tap_sel * $signed(p_data);
	assign take    = (state == MAC_TAKE_PIXEL) && p_req;

	//////////////////////////////////////////////////////////////////////
	// Window FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= MAC_IDLE;
			pix_cnt <= '0;
		end else begin
			case (state)
				MAC_IDLE: begin
					pix_cnt <= '0;
					// Opcode only matters with the first pixel
					if (p_req && p_op == WIN_REUSE) begin
						state <= MAC_TAKE_PIXEL;
					end else if (p_req && kernel_avail) begin
						state <= MAC_POP;
					end
				end
				// Taps settle one clock after the pop
				MAC_POP:        state <= MAC_TAKE_PIXEL;
				MAC_TAKE_PIXEL: begin
					if (p_req) begin
						pix_cnt <= pix_cnt + 1'b1;
						state   <= MAC_WAIT_DROP;
					end
				end
				MAC_WAIT_DROP: begin
					if (!p_req) begin
						if (pix_cnt == TAP_CNT_WIDTH'(KERNEL_SIZE)) begin
							state <= MAC_REPLY;
						end else begin
							state <= MAC_TAKE_PIXEL;
						end
					end
				end
				MAC_REPLY: begin
					if (res_ack) begin
						state <= MAC_REPLY_DROP;
					end
				end
				MAC_REPLY_DROP: begin
					if (!res_ack) begin
						state <= MAC_IDLE;
					end
				end
				default: state <= MAC_IDLE;
			endcase
		end
	end

	// Cleared between windows
	always_ff @(posedge clk) begin
		if (state == MAC_IDLE) begin
			acc_q <= '0;
		end else if (take) begin
			acc_q <= acc_q + product;
		end
	end

	assign load_kernel = (state == MAC_POP);
	assign p_ack       = (state == MAC_WAIT_DROP);
	assign res_req     = (state == MAC_REPLY);
	assign res_data    = acc_q;

	// Result must not move while the host may be sampling it
	assert property (@(posedge clk) disable iff (reset)
		res_req ##1 res_req |-> $stable(res_data));

endmodule

// ==== verilog/kernel_weight_buffer.sv ====
`timescale 1ns/1ns

module kernel_weight_buffer (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           word_valid,
	input  logic [conv_pkg::DATA_WIDTH-1:0] word_data,
	output logic                           buffer_ready,
	input  logic                           load_kernel,
	output logic                           kernel_avail,
	output logic                           kernel_valid,
	output logic [conv_pkg::DATA_WIDTH-1:0] tap_00,
	output logic [conv_pkg::DATA_WIDTH-1:0] tap_01,
	output logic [conv_pkg::DATA_WIDTH-1:0] tap_02,
	output logic [conv_pkg::DATA_WIDTH-1:0] tap_03,
	output logic [conv_pkg::DATA_WIDTH-1:0] tap_04,
	output logic [conv_pkg::DATA_WIDTH-1:0] tap_05,
	output logic [conv_pkg::DATA_WIDTH-1:0] tap_06,
	output logic [conv_pkg::DATA_WIDTH-1:0] tap_07,
	output logic [conv_pkg::DATA_WIDTH-1:0] tap_08
);

	import conv_pkg::*;

	logic [DATA_WIDTH-1:0]    shift_q [KERNEL_SIZE];
	logic [DATA_WIDTH-1:0]    tap_q [KERNEL_SIZE];
	logic [TAP_CNT_WIDTH-1:0] tap_cnt;
	logic                     write_kernel;
	logic [KERNEL_SIZE-1:0]   lane_full;
	logic [KERNEL_SIZE-1:0]   lane_empty;

	//////////////////////////////////////////////////////////////////////
	// Word collection
	//////////////////////////////////////////////////////////////////////

	// New word enters at the top, oldest ends up in tap 0
	always_ff @(posedge clk) begin
		if (word_valid) begin
			shift_q[KERNEL_SIZE-1] <= word_data;
			for (int i = 0; i < KERNEL_SIZE - 1; i++) begin
				shift_q[i] <= shift_q[i+1];
			end
		end
	end

	// Ninth word raises one write for all lanes
	always_ff @(posedge clk) begin
		if (reset) begin
			tap_cnt      <= '0;
			write_kernel <= 1'b0;
		end else begin
			write_kernel <= 1'b0;
			if (word_valid) begin
				if (tap_cnt == TAP_CNT_WIDTH'(KERNEL_SIZE - 1)) begin
					tap_cnt      <= '0;
					write_kernel <= 1'b1;
				end else begin
					tap_cnt <= tap_cnt + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Tap lanes
	//////////////////////////////////////////////////////////////////////
	for (genvar k = 0; k < KERNEL_SIZE; k++) begin : g_lane
		tap_fifo u_lane (
			.clk      (clk),
			.reset    (reset),
			.write    (write_kernel),
			.read     (load_kernel),
			.data_in  (shift_q[k]),
			.data_out (tap_q[k]),
			.full     (lane_full[k]),
			.empty    (lane_empty[k])
		);
	end

	// All lanes move together, lane 0 speaks for them
	assign buffer_ready = !lane_full[0];
	assign kernel_avail = !lane_empty[0];

	assign tap_00 = tap_q[0];
	assign tap_01 = tap_q[1];
	assign tap_02 = tap_q[2];
	assign tap_03 = tap_q[3];
	assign tap_04 = tap_q[4];
	assign tap_05 = tap_q[5];
	assign tap_06 = tap_q[6];
	assign tap_07 = tap_q[7];
	assign tap_08 = tap_q[8];

	// Set on first pop, then stays
	always_ff @(posedge clk) begin
		if (reset) begin
			kernel_valid <= 1'b0;
		end else if (load_kernel) begin
			kernel_valid <= 1'b1;
		end
	end

endmodule

// ==== verilog/tap_fifo.sv ====
`timescale 1ns/1ns

module tap_fifo (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           write,
	input  logic                           read,
	input  logic [conv_pkg::DATA_WIDTH-1:0] data_in,
	output logic [conv_pkg::DATA_WIDTH-1:0] data_out,
	output logic                           full,
	output logic                           empty
);

	import conv_pkg::*;

	logic [DATA_WIDTH-1:0] mem [KERNEL_DEPTH];
	logic [PTR_WIDTH-1:0]  wr_ptr;
	logic [PTR_WIDTH-1:0]  rd_ptr;

	// Same address, wrap bits differ when full
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[PTR_WIDTH-1] != rd_ptr[PTR_WIDTH-1]) &&
		(wr_ptr[PTR_WIDTH-2:0] == rd_ptr[PTR_WIDTH-2:0]);

	//////////////////////////////////////////////////////////////////////
	// Pointers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (write && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (read && !empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Storage and output register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (write && !full) begin
			mem[wr_ptr[PTR_WIDTH-2:0]] <= data_in;
		end
	end

	// Holds the popped tap until the next read
	always_ff @(posedge clk) begin
		if (read && !empty) begin
			data_out <= mem[rd_ptr[PTR_WIDTH-2:0]];
		end
	end

	// Receiver back-pressure must keep a full lane from being written
	assert property (@(posedge clk) disable iff (reset) write |-> !full);
	// Consumer only pops once a kernel is available
	assert property (@(posedge clk) disable iff (reset) read |-> !empty);

endmodule

// ==== verilog/weight_stream_rx.sv ====
`timescale 1ns/1ns

module weight_stream_rx (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           w_req,
	input  logic [conv_pkg::DATA_WIDTH-1:0] w_data,
	output logic                           w_ack,
	input  logic                           buffer_ready,
	output logic                           word_valid,
	output logic [conv_pkg::DATA_WIDTH-1:0] word_data
);

	import conv_pkg::*;

	rx_state_t state;

	//////////////////////////////////////////////////////////////////////
	// Four-phase handshake
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RX_IDLE;
		end else begin
			case (state)
				RX_IDLE: begin
					// Hold off the ack while the tap FIFOs are full
					if (w_req && buffer_ready) begin
						state <= RX_ACKED;
					end
				end
				RX_ACKED: begin
					state <= w_req ? RX_WAIT_DROP : RX_IDLE;
				end
				RX_WAIT_DROP: begin
					if (!w_req) begin
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Word captured on acceptance
	always_ff @(posedge clk) begin
		if (state == RX_IDLE && w_req && buffer_ready) begin
			word_data <= w_data;
		end
	end

	assign w_ack = (state != RX_IDLE);
	// One strobe per word, in the cycle the ack rises
	assign word_valid = (state == RX_ACKED);

	// Host keeps its request up until the ack arrives
	assert property (@(posedge clk) disable iff (reset)
		w_req && !w_ack |=> w_req || w_ack);

endmodule

// ==== verilog/conv_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared widths, depths and enums for the 3x3 convolution engine
//////////////////////////////////////////////////////////////////////

package conv_pkg;

	// Weight and pixel words are signed
	localparam int DATA_WIDTH = 16;
	// Two data widths plus four guard bits for nine products
	localparam int ACC_WIDTH = 36;

	localparam int KERNEL_SIZE = 9;
	// Kernels held per tap FIFO
	localparam int KERNEL_DEPTH = 4;
	localparam int TAP_CNT_WIDTH = 4;
	// Two address bits plus wrap bit
	localparam int PTR_WIDTH = 3;

	// Opcode sent with the first pixel of a window
	typedef enum logic {
		WIN_REUSE = 1'b0,
		WIN_NEXT  = 1'b1
	} win_op_t;

	// Window MAC states
	typedef enum logic [2:0] {
		MAC_IDLE, MAC_POP, MAC_TAKE_PIXEL, MAC_WAIT_DROP, MAC_REPLY, MAC_REPLY_DROP
	} mac_state_t;

	// Weight receiver states
	typedef enum logic [1:0] {RX_IDLE, RX_ACKED, RX_WAIT_DROP} rx_state_t;

endpackage
